//--- hdl/mm_decoder.sv
`timescale 1ns/1ps

module mm_decoder #(
    parameter int RAM_ADDR_WIDTH = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_i,
    input  mm_ram_pkg::bus_addr_t addr_i,
    input  logic                  we_i,
    input  mm_ram_pkg::bus_be_t   be_i,
    input  mm_ram_pkg::bus_data_t wdata_i,
    mm_mem_if.initiator           mem,
    mm_per_if.initiator           per,
    output mm_ram_pkg::rd_src_e   rd_src_o,
    output logic                  rsp_pending_o,
    output logic                  status_pass_o,
    output logic                  status_fail_o,
    output logic                  exit_strobe_o,
    output mm_ram_pkg::bus_data_t exit_data_o
);
    import mm_ram_pkg::*;

    logic    in_ram;
    logic    map_hit;
    rd_src_e rd_src_d;

    // RAM occupies the bottom 2**RAM_ADDR_WIDTH bytes
    assign in_ram  = (addr_i[31:RAM_ADDR_WIDTH] == '0);
    assign map_hit = addr_i inside {ADDR_TESTSTATUS, ADDR_EXIT, ADDR_TIMERREG,
                                    ADDR_TIMERVAL, ADDR_TICKS};

    // payload goes straight through, only the strobes are decoded
    assign mem.we    = we_i;
    assign mem.be    = be_i;
    assign mem.addr  = addr_i[RAM_ADDR_WIDTH-1:2];
    assign mem.wdata = wdata_i;
    assign per.wdata = wdata_i;

    always_comb begin
        mem.req           = 1'b0;
        per.timer_mask_we = 1'b0;
        per.timer_val_we  = 1'b0;
        per.ticks_clr     = 1'b0;
        status_pass_o     = 1'b0;
        status_fail_o     = 1'b0;
        exit_strobe_o     = 1'b0;
        exit_data_o       = '0;
        rd_src_d          = RD_ERR;

        if (req_i) begin
            if (in_ram) begin
                mem.req = 1'b1;
                if (!we_i) begin
                    rd_src_d = RD_RAM;
                end
            end else if (we_i) begin
                case (addr_i)
                    ADDR_TESTSTATUS: begin
                        // any other value is silently dropped
                        status_pass_o = (wdata_i == STATUS_PASS);
                        status_fail_o = (wdata_i == STATUS_FAIL);
                    end
                    ADDR_EXIT: begin
                        exit_strobe_o = 1'b1;
                        exit_data_o   = wdata_i;
                    end
                    ADDR_TIMERREG: per.timer_mask_we = 1'b1;
                    ADDR_TIMERVAL: per.timer_val_we  = 1'b1;
                    ADDR_TICKS:    per.ticks_clr     = 1'b1;
                    default: ;
                endcase
            end else if (addr_i == ADDR_TICKS) begin
                rd_src_d = RD_TICKS;
            end
        end
    end

    // response stage state, valid in the cycle after the request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_src_o      <= RD_ERR;
            rsp_pending_o <= 1'b0;
        end else begin
            rd_src_o      <= rd_src_d;
            rsp_pending_o <= req_i;
        end
    end

    a_no_unmapped_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_i && we_i |-> in_ram || map_hit)
        else $error("unmapped write to %08x with %08x", addr_i, wdata_i);

    // one target per request across RAM and peripherals
    a_one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({mem.req, per.timer_mask_we, per.timer_val_we, per.ticks_clr,
                  status_pass_o, status_fail_o, exit_strobe_o}));

endmodule

//--- hdl/mm_ram.sv
`timescale 1ns/1ps

module mm_ram #(
    parameter int RAM_ADDR_WIDTH = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  data_req_i,
    input  mm_ram_pkg::bus_addr_t data_addr_i,
    input  logic                  data_we_i,
    input  mm_ram_pkg::bus_be_t   data_be_i,
    input  mm_ram_pkg::bus_data_t data_wdata_i,
    output logic                  data_gnt_o,
    output logic                  data_rvalid_o,
    output mm_ram_pkg::bus_data_t data_rdata_o,

    input  mm_ram_pkg::irq_id_t   irq_id_i,
    input  logic                  irq_ack_i,
    output mm_ram_pkg::irq_vec_t  irq_o,

    output logic                  tests_passed_o,
    output logic                  tests_failed_o,
    output logic                  exit_valid_o,
    output mm_ram_pkg::bus_data_t exit_value_o
);
    import mm_ram_pkg::*;

    rd_src_e   rd_src;
    logic      rsp_pending;
    logic      status_pass;
    logic      status_fail;
    logic      exit_strobe;
    bus_data_t exit_data;

    mm_mem_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) mem_if ();
    mm_per_if per_if ();

    // never stalls, so every request is granted at once
    assign data_gnt_o = data_req_i;

    mm_decoder #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_decoder (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_i         (data_req_i),
        .addr_i        (data_addr_i),
        .we_i          (data_we_i),
        .be_i          (data_be_i),
        .wdata_i       (data_wdata_i),
        .mem           (mem_if.initiator),
        .per           (per_if.initiator),
        .rd_src_o      (rd_src),
        .rsp_pending_o (rsp_pending),
        .status_pass_o (status_pass),
        .status_fail_o (status_fail),
        .exit_strobe_o (exit_strobe),
        .exit_data_o   (exit_data)
    );

    mm_ram_array #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_ram (
        .clk_i (clk_i),
        .mem   (mem_if.target)
    );

    mm_timers u_timers (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .per       (per_if.target),
        .irq_id_i  (irq_id_i),
        .irq_ack_i (irq_ack_i),
        .irq_o     (irq_o)
    );

    mm_response u_response (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .rd_src_i       (rd_src),
        .rsp_pending_i  (rsp_pending),
        .ram_rdata_i    (mem_if.rdata),
        .ticks_i        (per_if.ticks),
        .status_pass_i  (status_pass),
        .status_fail_i  (status_fail),
        .exit_strobe_i  (exit_strobe),
        .exit_data_i    (exit_data),
        .rvalid_o       (data_rvalid_o),
        .rdata_o        (data_rdata_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

endmodule

//--- hdl/mm_ram_array.sv
`timescale 1ns/1ps

module mm_ram_array #(
    parameter int RAM_ADDR_WIDTH = 16
) (
    input logic      clk_i,
    mm_mem_if.target mem
);
    import mm_ram_pkg::*;

    localparam int NUM_WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

    bus_data_t mem_q [NUM_WORDS];
    bus_data_t rdata_q;

    // --------------------
    // storage
    // --------------------

    always_ff @(posedge clk_i) begin
        if (mem.req) begin
            if (mem.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (mem.be[i]) begin
                        mem_q[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
                    end
                end
            end else begin
                // read data holds until the next read
                rdata_q <= mem_q[mem.addr];
            end
        end
    end

    assign mem.rdata = rdata_q;

    // a write strobe with no enabled byte would be a decode error upstream
    a_write_has_be: assert property (@(posedge clk_i)
        mem.req && mem.we |-> mem.be != '0)
        else $error("RAM write to word %0d with no byte enables", mem.addr);

endmodule

//--- hdl/mm_ram_if.sv
`timescale 1ns/1ps

// decoder to RAM array, word addressed
interface mm_mem_if #(
    parameter int RAM_ADDR_WIDTH = 16
);
    import mm_ram_pkg::*;

    logic                      req;
    logic                      we;
    bus_be_t                   be;
    logic [RAM_ADDR_WIDTH-3:0] addr;
    bus_data_t                 wdata;
    bus_data_t                 rdata;

    modport initiator (output req, we, be, addr, wdata, input rdata);
    modport target (input req, we, be, addr, wdata, output rdata);

endinterface

// decoder to timer and cycle counter peripherals
interface mm_per_if;
    import mm_ram_pkg::*;

    logic      timer_mask_we;
    logic      timer_val_we;
    logic      ticks_clr;
    bus_data_t wdata;
    bus_data_t ticks;

    modport initiator (output timer_mask_we, timer_val_we, ticks_clr, wdata, input ticks);
    modport target (input timer_mask_we, timer_val_we, ticks_clr, wdata, output ticks);

endinterface

//--- hdl/mm_ram_pkg.sv
package mm_ram_pkg;

    // --------------------
    // bus types
    // --------------------

    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  bus_be_t;

    // one bit per interrupt line
    typedef logic [31:0] irq_vec_t;
    typedef logic [4:0]  irq_id_t;

    // source of the read data in the response cycle
    // RD_ERR also covers write responses, which carry no data
    typedef enum logic [1:0] {
        RD_RAM,
        RD_TICKS,
        RD_ERR
    } rd_src_e;

    // --------------------
    // address map
    // --------------------

    localparam bus_addr_t ADDR_TESTSTATUS = 32'h2000_0000;
    localparam bus_addr_t ADDR_EXIT       = 32'h2000_0004;
    localparam bus_addr_t ADDR_TIMERREG   = 32'h1500_0000;
    localparam bus_addr_t ADDR_TIMERVAL   = 32'h1500_0004;
    localparam bus_addr_t ADDR_TICKS      = 32'h1500_1004;

    // test status codes written to ADDR_TESTSTATUS
    localparam bus_data_t STATUS_PASS = 32'd123456789;
    localparam bus_data_t STATUS_FAIL = 32'd1;

endpackage

//--- hdl/mm_response.sv
`timescale 1ns/1ps

module mm_response (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  mm_ram_pkg::rd_src_e   rd_src_i,
    input  logic                  rsp_pending_i,
    input  mm_ram_pkg::bus_data_t ram_rdata_i,
    input  mm_ram_pkg::bus_data_t ticks_i,
    input  logic                  status_pass_i,
    input  logic                  status_fail_i,
    input  logic                  exit_strobe_i,
    input  mm_ram_pkg::bus_data_t exit_data_i,
    output logic                  rvalid_o,
    output mm_ram_pkg::bus_data_t rdata_o,
    output logic                  tests_passed_o,
    output logic                  tests_failed_o,
    output logic                  exit_valid_o,
    output mm_ram_pkg::bus_data_t exit_value_o
);
    import mm_ram_pkg::*;

    // --------------------
    // read data
    // --------------------

    // select and pending flag were registered at the request edge, as was
    // the RAM read, so the response lands one cycle after the request
    always_comb begin
        rdata_o = '0;
        if (rsp_pending_i) begin
            case (rd_src_i)
                RD_RAM:   rdata_o = ram_rdata_i;
                RD_TICKS: rdata_o = ticks_i;
                default:  rdata_o = '0;
            endcase
        end
    end

    assign rvalid_o = rsp_pending_i;

    // status and exit pulses
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else begin
            tests_passed_o <= status_pass_i;
            tests_failed_o <= status_fail_i;
            exit_valid_o   <= exit_strobe_i;
            exit_value_o   <= exit_data_i;
        end
    end

    a_pass_xor_fail: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(tests_passed_o && tests_failed_o))
        else $error("pass and fail reported together");

endmodule

//--- hdl/mm_timers.sv
`timescale 1ns/1ps

module mm_timers (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    mm_per_if.target             per,
    input  mm_ram_pkg::irq_id_t  irq_id_i,
    input  logic                 irq_ack_i,
    output mm_ram_pkg::irq_vec_t irq_o
);
    import mm_ram_pkg::*;

    irq_vec_t  mask_q;
    irq_vec_t  irq_q;
    bus_data_t cnt_q;
    bus_data_t ticks_q;

    // --------------------
    // interrupt timer
    // --------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= '0;
        end else begin
            if (per.timer_mask_we) begin
                mask_q <= per.wdata;
            end

            if (per.timer_val_we) begin
                cnt_q <= per.wdata;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end

            // expiry beats a coinciding acknowledge
            if (cnt_q == 32'd1) begin
                irq_q <= mask_q;
            end else if (irq_ack_i) begin
                irq_q[irq_id_i] <= 1'b0;
            end
        end
    end

    assign irq_o = irq_q;

    // --------------------
    // cycle counter
    // --------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ticks_q <= '0;
        end else if (per.ticks_clr) begin
            ticks_q <= '0;
        end else begin
            // wraps at 2**32
            ticks_q <= ticks_q + 1'b1;
        end
    end

    assign per.ticks = ticks_q;

    // pending irq bits always lie within the current mask
    a_irq_in_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (irq_q & ~mask_q) == '0)
        else $error("irq %08x outside mask %08x", irq_q, mask_q);

endmodule

//--- mm_ram.f
hdl/mm_ram_pkg.sv
hdl/mm_ram_if.sv
hdl/mm_decoder.sv
hdl/mm_ram_array.sv
hdl/mm_timers.sv
hdl/mm_response.sv
hdl/mm_ram.sv
verif/tb_mm_ram.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mm_ram -f mm_ram.f -o sim_mm_ram

# the simulator exits non-zero on a failed run, so keep its output for the search
sim_out=$(./obj_dir/sim_mm_ram 2>&1 || true)
printf '%s\n' "$sim_out"

if grep -q "^SIMULATION PASSED$" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- verif/tb_mm_ram.sv
`timescale 1ns/1ps

module tb_mm_ram;
    import mm_ram_pkg::*;

    localparam int RAM_ADDR_WIDTH = 10;
    localparam int RAM_BYTES      = 2 ** RAM_ADDR_WIDTH;
    localparam int CLK_PERIOD     = 4;
    localparam int NUM_FILL       = RAM_BYTES / 4;
    localparam int NUM_RAM        = 400;
    localparam int NUM_UNMAPPED   = 40;
    localparam int MAX_IDLE       = 2;
    localparam int TIMER_ROUNDS   = 3;
    // every phase bounded by its worst case cycle count, plus margin
    localparam int RUN_CYCLES = 16 + NUM_FILL + (NUM_RAM + NUM_UNMAPPED) * (1 + MAX_IDLE)
                              + TIMER_ROUNDS * 60 + 80;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 200;

    logic      clk_i = 1'b0;
    logic      rst_ni;
    logic      data_req_i;
    bus_addr_t data_addr_i;
    logic      data_we_i;
    bus_be_t   data_be_i;
    bus_data_t data_wdata_i;
    logic      data_gnt_o;
    logic      data_rvalid_o;
    bus_data_t data_rdata_o;
    irq_id_t   irq_id_i;
    logic      irq_ack_i;
    irq_vec_t  irq_o;
    logic      tests_passed_o;
    logic      tests_failed_o;
    logic      exit_valid_o;
    bus_data_t exit_value_o;

    // --------------------
    // reference model
    // --------------------
    logic [7:0] ram_model [RAM_BYTES];
    bus_data_t  exp_data_q [$];
    bit         exp_capture_q [$];
    bus_data_t  ticks_seen_q [$];
    irq_vec_t   mask_model;
    irq_vec_t   irq_model;
    bus_data_t  cnt_model;
    logic       exp_pass;
    logic       exp_fail;
    logic       exp_exit;
    bus_data_t  exp_exit_val;
    string      test_name;

    mm_ram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) u_dut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .irq_id_i       (irq_id_i),
        .irq_ack_i      (irq_ack_i),
        .irq_o          (irq_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string what, input bus_data_t exp, input bus_data_t act);
        if (exp !== act) begin
            abort_run($sformatf("mismatch %s %s: expected %08x, actual %08x",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("mismatch %s %s: expected %b, actual %b",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_irq(input string what, input irq_vec_t exp, input irq_vec_t act);
        if (exp !== act) begin
            abort_run($sformatf("mismatch %s %s: expected %08x, actual %08x",
                                test_name, what, exp, act));
        end
    endtask

    // fill word built from the whole byte address
    function automatic bus_data_t fill_word(input bus_addr_t addr);
        return {addr[15:0] ^ 16'hc3a5, ~addr[15:0]};
    endfunction

    function automatic bus_data_t model_word(input bus_addr_t addr);
        int base;
        base = int'(addr[RAM_ADDR_WIDTH-1:2]) * 4;
        return {ram_model[base+3], ram_model[base+2], ram_model[base+1], ram_model[base]};
    endfunction

    function automatic bus_addr_t random_unmapped_addr();
        bus_addr_t addr;
        do begin
            addr = $urandom;
        end while (addr[31:RAM_ADDR_WIDTH] == '0 ||
                   addr inside {ADDR_TESTSTATUS, ADDR_EXIT, ADDR_TIMERREG,
                                ADDR_TIMERVAL, ADDR_TICKS});
        return addr;
    endfunction

    // advance the model over one clock edge, using the inputs held in the ending cycle
    task automatic update_model();
        logic wr;
        int   base;
        wr = data_req_i && data_we_i;
        // expiry copies the mask, otherwise an ack clears its line
        if (cnt_model == 32'd1) begin
            irq_model = mask_model;
        end else if (irq_ack_i) begin
            irq_model[irq_id_i] = 1'b0;
        end
        if (wr && data_addr_i == ADDR_TIMERVAL) begin
            cnt_model = data_wdata_i;
        end else if (cnt_model != '0) begin
            cnt_model = cnt_model - 1;
        end
        if (wr && data_addr_i == ADDR_TIMERREG) begin
            mask_model = data_wdata_i;
        end
        exp_pass     = wr && data_addr_i == ADDR_TESTSTATUS && data_wdata_i == STATUS_PASS;
        exp_fail     = wr && data_addr_i == ADDR_TESTSTATUS && data_wdata_i == STATUS_FAIL;
        exp_exit     = wr && data_addr_i == ADDR_EXIT;
        exp_exit_val = data_wdata_i;
        if (wr && data_addr_i[31:RAM_ADDR_WIDTH] == '0) begin
            base = int'(data_addr_i[RAM_ADDR_WIDTH-1:2]) * 4;
            for (int b = 0; b < 4; b++) begin
                if (data_be_i[b]) begin
                    ram_model[base+b] = data_wdata_i[8*b +: 8];
                end
            end
        end
    endtask

    // one clock cycle: drive the inputs, then check the response to the last cycle
    task automatic run_cycle(input logic req, input logic we, input bus_addr_t addr,
                             input bus_be_t be, input bus_data_t wdata,
                             input logic ack, input irq_id_t id, input bit capture);
        logic      had_req;
        bus_data_t exp;
        bit        cap;
        @(posedge clk_i);
        had_req = data_req_i;
        update_model();
        #1;
        data_req_i   = req;
        data_we_i    = we;
        data_addr_i  = addr;
        data_be_i    = be;
        data_wdata_i = wdata;
        irq_ack_i    = ack;
        irq_id_i     = id;
        if (req) begin
            if (!we && addr[31:RAM_ADDR_WIDTH] == '0) begin
                exp_data_q.push_back(model_word(addr));
            end else begin
                exp_data_q.push_back('0);
            end
            exp_capture_q.push_back(capture);
        end
        @(negedge clk_i);
        check_bit("data_gnt_o", req, data_gnt_o);
        check_bit("data_rvalid_o", had_req, data_rvalid_o);
        if (had_req) begin
            exp = exp_data_q.pop_front();
            cap = exp_capture_q.pop_front();
            if (cap) begin
                ticks_seen_q.push_back(data_rdata_o);
            end else begin
                check_data("data_rdata_o", exp, data_rdata_o);
            end
        end else begin
            check_data("idle data_rdata_o", '0, data_rdata_o);
        end
        check_bit("tests_passed_o", exp_pass, tests_passed_o);
        check_bit("tests_failed_o", exp_fail, tests_failed_o);
        check_bit("exit_valid_o", exp_exit, exit_valid_o);
        if (exp_exit) begin
            check_data("exit_value_o", exp_exit_val, exit_value_o);
        end
        check_irq("irq_o", irq_model, irq_o);
    endtask

    task automatic bus_op(input logic we, input bus_addr_t addr, input bus_be_t be,
                          input bus_data_t wdata, input bit capture);
        run_cycle(1'b1, we, addr, be, wdata, 1'b0, '0, capture);
    endtask

    task automatic idle(input logic ack, input irq_id_t id);
        run_cycle(1'b0, 1'b0, '0, '0, '0, ack, id, 1'b0);
    endtask

    task automatic ram_traffic(input int count);
        bus_addr_t addr;
        logic      we;
        for (int i = 0; i < count; i++) begin
            addr = bus_addr_t'($urandom_range(0, NUM_FILL - 1)) << 2;
            we   = $urandom_range(0, 1);
            if (we) begin
                bus_op(1'b1, addr, bus_be_t'($urandom_range(1, 15)), $urandom, 1'b0);
            end else begin
                bus_op(1'b0, addr, bus_be_t'($urandom), '0, 1'b0);
            end
            repeat ($urandom_range(0, MAX_IDLE)) idle(1'b0, '0);
        end
    endtask

    task automatic timer_round();
        irq_vec_t mask;
        irq_vec_t pending;
        int       n;
        irq_id_t  id;
        mask = $urandom;
        if (mask == '0) begin
            mask = 32'h1;
        end
        n = $urandom_range(1, 20);
        bus_op(1'b1, ADDR_TIMERREG, 4'hf, mask, 1'b0);
        bus_op(1'b1, ADDR_TIMERVAL, 4'hf, bus_data_t'(n), 1'b0);
        repeat (n) idle(1'b0, '0);
        check_irq("before expiry", '0, irq_o);
        idle(1'b0, '0);
        check_irq("at expiry", mask, irq_o);
        // ack the set lines one by one in random order
        pending = mask;
        while (pending != '0) begin
            do begin
                id = irq_id_t'($urandom_range(0, 31));
            end while (!pending[id]);
            pending[id] = 1'b0;
            idle(1'b1, id);
        end
        idle(1'b0, '0);
        check_irq("after acks", '0, irq_o);
    endtask

    initial begin
        bus_data_t v;
        int        d;
        void'($urandom(32'h499b0bac));
        rst_ni       = 1'b0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_id_i     = '0;
        irq_ack_i    = 1'b0;
        mask_model   = '0;
        irq_model    = '0;
        cnt_model    = '0;
        exp_pass     = 1'b0;
        exp_fail     = 1'b0;
        exp_exit     = 1'b0;
        exp_exit_val = '0;
        test_name    = "reset";
        repeat (16) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        test_name = "ram fill";
        for (int w = 0; w < NUM_FILL; w++) begin
            bus_op(1'b1, bus_addr_t'(w * 4), 4'hf, fill_word(bus_addr_t'(w * 4)), 1'b0);
        end
        test_name = "ram traffic";
        ram_traffic(NUM_RAM / 2);

        test_name = "unmapped reads";
        for (int i = 0; i < NUM_UNMAPPED; i++) begin
            bus_op(1'b0, random_unmapped_addr(), bus_be_t'($urandom), '0, 1'b0);
            repeat ($urandom_range(0, MAX_IDLE)) idle(1'b0, '0);
        end
        // RAM must still match the model after the unmapped reads
        test_name = "ram traffic after unmapped";
        ram_traffic(NUM_RAM - NUM_RAM / 2);

        test_name = "status and exit";
        bus_op(1'b1, ADDR_TESTSTATUS, 4'hf, STATUS_PASS, 1'b0);
        idle(1'b0, '0);
        bus_op(1'b1, ADDR_TESTSTATUS, 4'hf, STATUS_FAIL, 1'b0);
        do begin
            v = $urandom;
        end while (v == STATUS_PASS || v == STATUS_FAIL);
        bus_op(1'b1, ADDR_TESTSTATUS, 4'hf, v, 1'b0);
        bus_op(1'b1, ADDR_EXIT, 4'hf, $urandom, 1'b0);
        idle(1'b0, '0);

        test_name = "timer";
        repeat (TIMER_ROUNDS) timer_round();

        test_name = "cycle counter";
        d = $urandom_range(1, 30);
        bus_op(1'b1, ADDR_TICKS, 4'hf, $urandom, 1'b0);
        repeat ($urandom_range(0, 3)) idle(1'b0, '0);
        bus_op(1'b0, ADDR_TICKS, 4'hf, '0, 1'b1);
        repeat (d - 1) idle(1'b0, '0);
        bus_op(1'b0, ADDR_TICKS, 4'hf, '0, 1'b1);
        idle(1'b0, '0);
        idle(1'b0, '0);
        if (ticks_seen_q.size() != 2) begin
            abort_run("cycle counter reads did not return two responses");
        end
        check_data("ticks delta", bus_data_t'(d), ticks_seen_q[1] - ticks_seen_q[0]);

        if (exp_data_q.size() != 0) begin
            abort_run("requests left without a response at the end of the run");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout: the run did not finish within the expected number of cycles");
    end

endmodule
